// File: compile.f
rtl/msrh_conf_pkg.sv
rtl/msrh_lsu_pkg.sv
rtl/l2c_arbiter.sv
rtl/l2_behavior_ram.sv
rtl/l2c_resp_router.sv
rtl/msrh_l2_subsystem.sv
testbench/msrh_l2_assert.sv
testbench/msrh_l2_tb.sv

// File: rtl/l2_behavior_ram.sv
`default_nettype none

module l2_behavior_ram
   import msrh_conf_pkg::*;
   import msrh_lsu_pkg::*;
  #(
    parameter int     RD_LAT    = 10,
    parameter int     MEM_WORDS = 256,
    parameter paddr_t BASE_ADDR = 'h8000_0000
    )
  (
   input  logic     i_clk,
   input  logic     i_msrh_reset_n,

   input  logic     i_req_valid,
   input  l2_req_t  i_req,
   output logic     o_req_ready,

   output logic     o_resp_valid,
   output l2_resp_t o_resp,
   input  logic     i_resp_ready
   );

localparam int BYTES   = DATA_W / 8;
localparam int OFS_W   = $clog2(BYTES);
localparam int IDX_W   = $clog2(MEM_WORDS);
localparam int Q_DEPTH = RD_LAT + 2;
localparam int PTR_W   = $clog2(Q_DEPTH);
localparam int CNT_W   = $clog2(Q_DEPTH + 1);

data_t r_mem [MEM_WORDS];

paddr_t           w_offset;
logic             w_in_range;
logic [IDX_W-1:0] w_idx;
logic             w_req_fire;
logic             w_rd_accept;
logic             w_wr_accept;

// read latency line
logic [RD_LAT-1:0] r_line_valid;
l2_resp_t          r_line [RD_LAT];

// response queue
l2_resp_t          r_q [Q_DEPTH];
logic [PTR_W-1:0]  r_wr_ptr;
logic [PTR_W-1:0]  r_rd_ptr;
logic [CNT_W-1:0]  r_q_cnt;
logic [CNT_W-1:0]  r_inflight;
logic              w_push;
logic              w_pop;

// address decode against the memory window
assign w_offset   = i_req.addr - BASE_ADDR;
assign w_in_range = (i_req.addr >= BASE_ADDR) &&
                    (w_offset[PADDR_W-1:OFS_W] < (PADDR_W-OFS_W)'(MEM_WORDS));
assign w_idx      = w_offset[OFS_W +: IDX_W];

assign w_req_fire  = i_req_valid & o_req_ready;
assign w_rd_accept = w_req_fire & (i_req.cmd == M_XRD);
// out of range writes are dropped here
assign w_wr_accept = w_req_fire & (i_req.cmd == M_XWR) & w_in_range;

always_ff @(posedge i_clk) begin
   if (w_wr_accept) begin
      for (int b = 0; b < BYTES; b++) begin
         if (i_req.byte_en[b]) begin
            r_mem[w_idx][b*8 +: 8] <= i_req.data[b*8 +: 8];
         end
      end
   end
end

always_ff @(posedge i_clk) begin
   if (!i_msrh_reset_n) begin
      r_line_valid <= '0;
   end else begin
      r_line_valid[0] <= w_rd_accept;
      for (int i = 1; i < RD_LAT; i++) begin
         r_line_valid[i] <= r_line_valid[i-1];
      end
   end
end

// memory is sampled at the acceptance edge, zero outside the window
always_ff @(posedge i_clk) begin
   r_line[0].tag  <= i_req.tag;
   r_line[0].data <= w_in_range ? r_mem[w_idx] : '0;
   for (int i = 1; i < RD_LAT; i++) begin
      r_line[i] <= r_line[i-1];
   end
end

assign w_push = r_line_valid[RD_LAT-1];
assign w_pop  = o_resp_valid & i_resp_ready;

always_ff @(posedge i_clk) begin
   if (!i_msrh_reset_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_q_cnt  <= '0;
   end else begin
      if (w_push) begin
         r_wr_ptr <= (r_wr_ptr == PTR_W'(Q_DEPTH-1)) ? '0 : r_wr_ptr + 1'b1;
      end
      if (w_pop) begin
         r_rd_ptr <= (r_rd_ptr == PTR_W'(Q_DEPTH-1)) ? '0 : r_rd_ptr + 1'b1;
      end
      case ({w_push, w_pop})
         2'b10:   r_q_cnt <= r_q_cnt + 1'b1;
         2'b01:   r_q_cnt <= r_q_cnt - 1'b1;
         default: r_q_cnt <= r_q_cnt;
      endcase
   end
end

always_ff @(posedge i_clk) begin
   if (w_push) begin
      r_q[r_wr_ptr] <= r_line[RD_LAT-1];
   end
end

// reads in the line plus reads in the queue
always_ff @(posedge i_clk) begin
   if (!i_msrh_reset_n) begin
      r_inflight <= '0;
   end else begin
      case ({w_rd_accept, w_pop})
         2'b10:   r_inflight <= r_inflight + 1'b1;
         2'b01:   r_inflight <= r_inflight - 1'b1;
         default: r_inflight <= r_inflight;
      endcase
   end
end

// queue can always absorb everything still in the line
assign o_req_ready = r_inflight < CNT_W'(Q_DEPTH);

assign o_resp_valid = (r_q_cnt != '0);
assign o_resp       = r_q[r_rd_ptr];

endmodule // l2_behavior_ram

`default_nettype wire

// File: rtl/l2c_arbiter.sv
`default_nettype none

module l2c_arbiter
   import msrh_lsu_pkg::*;
  (
   /* ELF loader */
   input  logic     i_elf_req_valid,
   input  mem_req_t i_elf_req,
   output logic     o_elf_req_ready,

   /* instruction cache */
   input  logic     i_ic_req_valid,
   input  mem_req_t i_ic_req,
   output logic     o_ic_req_ready,

   /* L1 data cache */
   input  logic     i_l1d_req_valid,
   input  mem_req_t i_l1d_req,
   output logic     o_l1d_req_ready,

   /* page-table walker */
   input  logic     i_ptw_req_valid,
   input  mem_req_t i_ptw_req,
   output logic     o_ptw_req_ready,

   /* merged request to L2 */
   output logic     o_l2_req_valid,
   output l2_req_t  o_l2_req,
   input  logic     i_l2_req_ready
   );

src_id_t  w_sel_src;
mem_req_t w_sel_req;
logic     w_sel_valid;

assign w_sel_valid = i_elf_req_valid | i_l1d_req_valid | i_ptw_req_valid | i_ic_req_valid;

// fixed priority: elf first, then l1d, ptw and ic last
always_comb begin
   if (i_elf_req_valid) begin
      w_sel_src = SRC_ELF;
      w_sel_req = i_elf_req;
   end else if (i_l1d_req_valid) begin
      w_sel_src = SRC_L1D;
      w_sel_req = i_l1d_req;
   end else if (i_ptw_req_valid) begin
      w_sel_src = SRC_PTW;
      w_sel_req = i_ptw_req;
   end else begin
      // also taken when nothing is pending, valid stays low then
      w_sel_src = SRC_IC;
      w_sel_req = i_ic_req;
   end
end

always_comb begin
   o_l2_req.cmd     = w_sel_req.cmd;
   o_l2_req.addr    = w_sel_req.addr;
   // source id goes above the requester tag
   o_l2_req.tag     = {w_sel_src, w_sel_req.tag};
   o_l2_req.data    = w_sel_req.data;
   o_l2_req.byte_en = w_sel_req.byte_en;
end

assign o_l2_req_valid = w_sel_valid;

// only the winner sees the L2 ready
assign o_elf_req_ready = w_sel_valid & (w_sel_src == SRC_ELF) & i_l2_req_ready;
assign o_ic_req_ready  = w_sel_valid & (w_sel_src == SRC_IC)  & i_l2_req_ready;
assign o_l1d_req_ready = w_sel_valid & (w_sel_src == SRC_L1D) & i_l2_req_ready;
assign o_ptw_req_ready = w_sel_valid & (w_sel_src == SRC_PTW) & i_l2_req_ready;

endmodule // l2c_arbiter

`default_nettype wire

// File: rtl/l2c_resp_router.sv
`default_nettype none

module l2c_resp_router
   import msrh_conf_pkg::*;
   import msrh_lsu_pkg::*;
  (
   /* response from L2 */
   input  logic      i_l2_resp_valid,
   input  l2_resp_t  i_l2_resp,
   output logic      o_l2_resp_ready,

   output logic      o_ic_resp_valid,
   output mem_resp_t o_ic_resp,
   input  logic      i_ic_resp_ready,

   output logic      o_l1d_resp_valid,
   output mem_resp_t o_l1d_resp,
   input  logic      i_l1d_resp_ready,

   output logic      o_ptw_resp_valid,
   output mem_resp_t o_ptw_resp,
   input  logic      i_ptw_resp_ready
   );

src_id_t   w_src;
mem_resp_t w_resp;

// upper tag bits name the issuing port
assign w_src       = src_id_t'(i_l2_resp.tag[L2_TAG_W-1 -: SRC_W]);
assign w_resp.tag  = i_l2_resp.tag[TAG_W-1:0];
assign w_resp.data = i_l2_resp.data;

assign o_ic_resp  = w_resp;
assign o_l1d_resp = w_resp;
assign o_ptw_resp = w_resp;

assign o_ic_resp_valid  = i_l2_resp_valid & (w_src == SRC_IC);
assign o_l1d_resp_valid = i_l2_resp_valid & (w_src == SRC_L1D);
assign o_ptw_resp_valid = i_l2_resp_valid & (w_src == SRC_PTW);

always_comb begin
   case (w_src)
      SRC_IC:  o_l2_resp_ready = i_ic_resp_ready;
      SRC_L1D: o_l2_resp_ready = i_l1d_resp_ready;
      SRC_PTW: o_l2_resp_ready = i_ptw_resp_ready;
      // loader has no response side, sink it
      default: o_l2_resp_ready = 1'b1;
   endcase
end

endmodule // l2c_resp_router

`default_nettype wire

// File: rtl/msrh_conf_pkg.sv
`default_nettype none

package msrh_conf_pkg;

// physical address and bus data widths
localparam int PADDR_W = 32;
localparam int DATA_W  = 64;

// requester tag as seen on each port
localparam int TAG_W = 4;

// source id is placed above the requester tag on the L2 side
localparam int SRC_W    = 2;
localparam int L2_TAG_W = SRC_W + TAG_W;

typedef logic [PADDR_W-1:0]  paddr_t;
typedef logic [DATA_W-1:0]   data_t;
typedef logic [DATA_W/8-1:0] byte_en_t;
typedef logic [TAG_W-1:0]    tag_t;
typedef logic [L2_TAG_W-1:0] l2_tag_t;

endpackage // msrh_conf_pkg

`default_nettype wire

// File: rtl/msrh_l2_subsystem.sv
`default_nettype none

module msrh_l2_subsystem
   import msrh_conf_pkg::*;
   import msrh_lsu_pkg::*;
  #(
    parameter int     RD_LAT    = 10,
    parameter int     MEM_WORDS = 256,
    parameter paddr_t BASE_ADDR = 'h8000_0000
    )
  (
   input  logic      i_clk,
   input  logic      i_msrh_reset_n,

   /* from ELF loader, request only */
   input  logic      i_elf_req_valid,
   input  mem_req_t  i_elf_req,
   output logic      o_elf_req_ready,

   /* instruction cache */
   input  logic      i_ic_req_valid,
   input  mem_req_t  i_ic_req,
   output logic      o_ic_req_ready,

   output logic      o_ic_resp_valid,
   output mem_resp_t o_ic_resp,
   input  logic      i_ic_resp_ready,

   /* L1 data cache */
   input  logic      i_l1d_req_valid,
   input  mem_req_t  i_l1d_req,
   output logic      o_l1d_req_ready,

   output logic      o_l1d_resp_valid,
   output mem_resp_t o_l1d_resp,
   input  logic      i_l1d_resp_ready,

   /* page-table walker */
   input  logic      i_ptw_req_valid,
   input  mem_req_t  i_ptw_req,
   output logic      o_ptw_req_ready,

   output logic      o_ptw_resp_valid,
   output mem_resp_t o_ptw_resp,
   input  logic      i_ptw_resp_ready
   );

// merged L2 side
logic     w_l2_req_valid;
l2_req_t  w_l2_req;
logic     w_l2_req_ready;

logic     w_l2_resp_valid;
l2_resp_t w_l2_resp;
logic     w_l2_resp_ready;

l2c_arbiter
u_l2c_arbiter
  (
   .i_elf_req_valid (i_elf_req_valid),
   .i_elf_req       (i_elf_req      ),
   .o_elf_req_ready (o_elf_req_ready),
   .i_ic_req_valid  (i_ic_req_valid ),
   .i_ic_req        (i_ic_req       ),
   .o_ic_req_ready  (o_ic_req_ready ),
   .i_l1d_req_valid (i_l1d_req_valid),
   .i_l1d_req       (i_l1d_req      ),
   .o_l1d_req_ready (o_l1d_req_ready),
   .i_ptw_req_valid (i_ptw_req_valid),
   .i_ptw_req       (i_ptw_req      ),
   .o_ptw_req_ready (o_ptw_req_ready),
   .o_l2_req_valid  (w_l2_req_valid ),
   .o_l2_req        (w_l2_req       ),
   .i_l2_req_ready  (w_l2_req_ready )
   );

l2_behavior_ram
  #(
    .RD_LAT    (RD_LAT   ),
    .MEM_WORDS (MEM_WORDS),
    .BASE_ADDR (BASE_ADDR)
    )
u_l2_behavior_ram
  (
   .i_clk          (i_clk          ),
   .i_msrh_reset_n (i_msrh_reset_n ),
   .i_req_valid    (w_l2_req_valid ),
   .i_req          (w_l2_req       ),
   .o_req_ready    (w_l2_req_ready ),
   .o_resp_valid   (w_l2_resp_valid),
   .o_resp         (w_l2_resp      ),
   .i_resp_ready   (w_l2_resp_ready)
   );

l2c_resp_router
u_l2c_resp_router
  (
   .i_l2_resp_valid  (w_l2_resp_valid ),
   .i_l2_resp        (w_l2_resp       ),
   .o_l2_resp_ready  (w_l2_resp_ready ),
   .o_ic_resp_valid  (o_ic_resp_valid ),
   .o_ic_resp        (o_ic_resp       ),
   .i_ic_resp_ready  (i_ic_resp_ready ),
   .o_l1d_resp_valid (o_l1d_resp_valid),
   .o_l1d_resp       (o_l1d_resp      ),
   .i_l1d_resp_ready (i_l1d_resp_ready),
   .o_ptw_resp_valid (o_ptw_resp_valid),
   .o_ptw_resp       (o_ptw_resp      ),
   .i_ptw_resp_ready (i_ptw_resp_ready)
   );

endmodule // msrh_l2_subsystem

`default_nettype wire

// File: rtl/msrh_lsu_pkg.sv
`default_nettype none

package msrh_lsu_pkg;

import msrh_conf_pkg::*;

// memory command, same encoding as the core's load/store commands
typedef enum logic [4:0] {
   M_XRD = 5'b00000,
   M_XWR = 5'b00001
} mem_cmd_t;

// requester ids, carried in the upper bits of the L2 tag
typedef enum logic [SRC_W-1:0] {
   SRC_ELF = 2'd0,
   SRC_IC  = 2'd1,
   SRC_L1D = 2'd2,
   SRC_PTW = 2'd3
} src_id_t;

/* request as issued by a requester */
typedef struct packed {
   mem_cmd_t cmd;
   paddr_t   addr;
   tag_t     tag;
   data_t    data;
   byte_en_t byte_en;
} mem_req_t;

/* request after the arbiter, tag widened */
typedef struct packed {
   mem_cmd_t cmd;
   paddr_t   addr;
   l2_tag_t  tag;
   data_t    data;
   byte_en_t byte_en;
} l2_req_t;

typedef struct packed {
   tag_t  tag;
   data_t data;
} mem_resp_t;

typedef struct packed {
   l2_tag_t tag;
   data_t   data;
} l2_resp_t;

endpackage // msrh_lsu_pkg

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the L2 request path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
   --top-module msrh_l2_tb \
   --Mdir obj_dir -o msrh_l2_sim \
   -f compile.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/msrh_l2_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
   exit 0
fi
exit 1

// File: testbench/msrh_l2_assert.sv
`default_nettype none

module msrh_l2_assert
   import msrh_lsu_pkg::*;
  (
   input  logic      i_clk,
   input  logic      i_msrh_reset_n,

   input  logic      o_elf_req_ready,
   input  logic      o_ic_req_ready,
   input  logic      o_l1d_req_ready,
   input  logic      o_ptw_req_ready,

   input  logic      o_ic_resp_valid,
   input  mem_resp_t o_ic_resp,
   input  logic      i_ic_resp_ready,
   input  logic      o_l1d_resp_valid,
   input  mem_resp_t o_l1d_resp,
   input  logic      i_l1d_resp_ready,
   input  logic      o_ptw_resp_valid,
   input  mem_resp_t o_ptw_resp,
   input  logic      i_ptw_resp_ready
   );

// number of assertion failures
int fail_cnt = 0;

// a stalled response holds valid and payload
a_ic_resp_stable: assert property (@(posedge i_clk) disable iff (!i_msrh_reset_n)
   (o_ic_resp_valid && !i_ic_resp_ready) |=> (o_ic_resp_valid && $stable(o_ic_resp)))
   else begin
      $error("ic response changed while stalled");
      fail_cnt++;
   end

a_l1d_resp_stable: assert property (@(posedge i_clk) disable iff (!i_msrh_reset_n)
   (o_l1d_resp_valid && !i_l1d_resp_ready) |=> (o_l1d_resp_valid && $stable(o_l1d_resp)))
   else begin
      $error("l1d response changed while stalled");
      fail_cnt++;
   end

a_ptw_resp_stable: assert property (@(posedge i_clk) disable iff (!i_msrh_reset_n)
   (o_ptw_resp_valid && !i_ptw_resp_ready) |=> (o_ptw_resp_valid && $stable(o_ptw_resp)))
   else begin
      $error("ptw response changed while stalled");
      fail_cnt++;
   end

// at most one requester is granted per cycle
a_one_grant: assert property (@(posedge i_clk) disable iff (!i_msrh_reset_n)
   $onehot0({o_elf_req_ready, o_ic_req_ready, o_l1d_req_ready, o_ptw_req_ready}))
   else begin
      $error("more than one request ready in the same cycle");
      fail_cnt++;
   end

endmodule // msrh_l2_assert

`default_nettype wire

// File: testbench/msrh_l2_tb.sv
`default_nettype none

module msrh_l2_tb
   import msrh_conf_pkg::*;
   import msrh_lsu_pkg::*;
   ();

localparam int     RD_LAT    = 4;
localparam int     MEM_WORDS = 64;
localparam int     IDX_W     = $clog2(MEM_WORDS);
localparam paddr_t BASE      = 32'h8000_0000;
localparam int     TIMEOUT   = 100;

// rows that share a wave are offered in the same cycle
typedef struct packed {
   int       test;
   int       wave;
   src_id_t  port;
   mem_cmd_t cmd;
   paddr_t   addr;
   tag_t     tag;
   data_t    data;
   byte_en_t byte_en;
   src_id_t  exp_port;
} row_t;

typedef struct packed {
   src_id_t port;
   tag_t    tag;
   data_t   data;
   int      acc_cyc;
   logic    lat_chk;
} exp_t;

logic      clk;
logic      rst_n;
logic      req_valid [4];
mem_req_t  req_pl [4];
wire [3:0] req_ready;
logic      ic_rdy;
logic      l1d_rdy;
logic      ptw_rdy;
logic      ic_vld;
logic      l1d_vld;
logic      ptw_vld;
mem_resp_t ic_resp;
mem_resp_t l1d_resp;
mem_resp_t ptw_resp;

row_t  rows [$];
exp_t  exp_q [$];
data_t model [MEM_WORDS];
int    cyc = 0;
int    err_cnt;
int    pass_cnt;
int    fail_cnt;
logic  bp_mode;
logic  timed_out;

initial begin
   clk = 1'b0;
   forever #4 clk = ~clk;
end

always @(posedge clk) cyc <= cyc + 1;

msrh_l2_subsystem
  #(
    .RD_LAT    (RD_LAT   ),
    .MEM_WORDS (MEM_WORDS),
    .BASE_ADDR (BASE     )
    )
dut
  (
   .i_clk            (clk               ),
   .i_msrh_reset_n   (rst_n             ),
   .i_elf_req_valid  (req_valid[SRC_ELF]),
   .i_elf_req        (req_pl[SRC_ELF]   ),
   .o_elf_req_ready  (req_ready[SRC_ELF]),
   .i_ic_req_valid   (req_valid[SRC_IC] ),
   .i_ic_req         (req_pl[SRC_IC]    ),
   .o_ic_req_ready   (req_ready[SRC_IC] ),
   .o_ic_resp_valid  (ic_vld            ),
   .o_ic_resp        (ic_resp           ),
   .i_ic_resp_ready  (ic_rdy            ),
   .i_l1d_req_valid  (req_valid[SRC_L1D]),
   .i_l1d_req        (req_pl[SRC_L1D]   ),
   .o_l1d_req_ready  (req_ready[SRC_L1D]),
   .o_l1d_resp_valid (l1d_vld           ),
   .o_l1d_resp       (l1d_resp          ),
   .i_l1d_resp_ready (l1d_rdy           ),
   .i_ptw_req_valid  (req_valid[SRC_PTW]),
   .i_ptw_req        (req_pl[SRC_PTW]   ),
   .o_ptw_req_ready  (req_ready[SRC_PTW]),
   .o_ptw_resp_valid (ptw_vld           ),
   .o_ptw_resp       (ptw_resp          ),
   .i_ptw_resp_ready (ptw_rdy           )
   );

bind msrh_l2_subsystem msrh_l2_assert u_msrh_l2_assert (.*);

function automatic string port_name(input src_id_t p);
   case (p)
      SRC_ELF: return "elf";
      SRC_IC:  return "ic";
      SRC_L1D: return "l1d";
      default: return "ptw";
   endcase
endfunction

function automatic string test_name(input int t);
   case (t)
      1:       return "loader write then ic read";
      2:       return "l1d partial write merge";
      3:       return "fixed priority grant";
      4:       return "ptw and l1d reads in flight";
      5:       return "ic response back-pressure";
      default: return "out of range access with stalled l1d and ptw";
   endcase
endfunction

// loader first, then L1D, PTW and the instruction cache last
function automatic src_id_t expected_winner(input logic [3:0] pend);
   if (pend[SRC_ELF]) return SRC_ELF;
   if (pend[SRC_L1D]) return SRC_L1D;
   if (pend[SRC_PTW]) return SRC_PTW;
   return SRC_IC;
endfunction

function automatic logic in_window(input paddr_t a);
   return (a >= BASE) && ((a - BASE) < paddr_t'(8 * MEM_WORDS));
endfunction

function automatic paddr_t word_addr(input int i);
   return BASE + paddr_t'(8 * i);
endfunction

task automatic add_row(input int test, input int wave, input src_id_t port,
                       input mem_cmd_t cmd, input paddr_t addr, input tag_t tag,
                       input byte_en_t be, input src_id_t exp_port);
   rows.push_back(row_t'{test, wave, port, cmd, addr, tag, {$urandom, $urandom}, be, exp_port});
endtask

task automatic write_row(input int test, input int wave, input src_id_t port,
                         input paddr_t addr, input byte_en_t be);
   add_row(test, wave, port, M_XWR, addr, '0, be, SRC_ELF);
endtask

task automatic read_row(input int test, input int wave, input src_id_t port,
                        input paddr_t addr, input tag_t tag);
   add_row(test, wave, port, M_XRD, addr, tag, '1, port);
endtask

task automatic build_table();
   // loader fills four words and ic reads three back
   for (int i = 0; i < 4; i++) begin
      write_row(1, i, SRC_ELF, word_addr(i), 8'hff);
   end
   for (int i = 0; i < 3; i++) begin
      read_row(1, 4 + i, SRC_IC, word_addr(i), tag_t'(i + 1));
   end
   write_row(2, 7, SRC_L1D, word_addr(1), 8'h0f);
   write_row(2, 8, SRC_L1D, word_addr(1), 8'h30);
   read_row(2, 9, SRC_L1D, word_addr(1), 4'h4);
   // all four ports valid together
   // ic reads the word the loader writes in that wave
   write_row(3, 10, SRC_ELF, word_addr(4), 8'hff);
   read_row(3, 10, SRC_IC, word_addr(4), 4'h9);
   read_row(3, 10, SRC_L1D, word_addr(0), 4'h7);
   read_row(3, 10, SRC_PTW, word_addr(2), 4'h8);
   for (int i = 0; i < 4; i++) begin
      read_row(4, 11 + i, (i % 2 == 0) ? SRC_PTW : SRC_L1D, word_addr(i), tag_t'(i + 1));
   end
   // more reads than the queue holds
   for (int i = 0; i < 9; i++) begin
      read_row(5, 15 + i, SRC_IC, word_addr(i % 5), tag_t'(i));
   end
   read_row(6, 24, SRC_IC, BASE - 32'd8, 4'ha);
   // one word past the end aliases word 0 without the range test
   write_row(6, 25, SRC_ELF, word_addr(MEM_WORDS), 8'hff);
   read_row(6, 26, SRC_L1D, word_addr(0), 4'hb);
   read_row(6, 27, SRC_PTW, word_addr(MEM_WORDS), 4'hc);
endtask

// model update or expected response at the acceptance edge
task automatic accept_row(input row_t r);
   paddr_t           offset;
   logic [IDX_W-1:0] idx;
   offset = r.addr - BASE;
   idx = offset[3 +: IDX_W];
   if (r.cmd == M_XWR) begin
      if (in_window(r.addr)) begin
         for (int b = 0; b < 8; b++) begin
            if (r.byte_en[b]) model[idx][b*8 +: 8] = r.data[b*8 +: 8];
         end
      end
   end else if (r.exp_port != SRC_ELF) begin
      exp_q.push_back(exp_t'{r.exp_port, r.tag, in_window(r.addr) ? model[idx] : '0,
                             cyc + 1, !bp_mode});
   end
endtask

task automatic issue_wave(input int lo, input int hi);
   logic [3:0] pend;
   int         row_of [4];
   src_id_t    win;
   logic       acc;
   int         t;
   pend = '0;
   for (int i = lo; i < hi; i++) begin
      pend[rows[i].port] = 1'b1;
      row_of[rows[i].port] = i;
      req_valid[rows[i].port] = 1'b1;
      req_pl[rows[i].port] = mem_req_t'{rows[i].cmd, rows[i].addr, rows[i].tag,
                                        rows[i].data, rows[i].byte_en};
   end
   t = 0;
   while (pend != '0 && !timed_out) begin
      @(negedge clk);
      win = expected_winner(pend);
      acc = req_ready[win];
      if (req_ready != '0 && req_ready != (4'b0001 << win)) begin
         err_cnt++;
         $display("Fail t=%0t {ptw,l1d,ic,elf}_req_ready expected %b got %b",
                  $time, 4'b0001 << win, req_ready);
      end
      if (acc) accept_row(rows[row_of[win]]);
      @(posedge clk);
      #1;
      if (acc) begin
         pend[win] = 1'b0;
         req_valid[win] = 1'b0;
      end
      t++;
      if (t > TIMEOUT) begin
         timed_out = 1'b1;
         err_cnt++;
         $display("timeout: request on the %s port was never accepted", port_name(win));
      end
   end
endtask

task automatic check_response(input src_id_t p, input mem_resp_t r);
   exp_t e;
   if (exp_q.size() == 0) begin
      err_cnt++;
      $display("response on the %s port at %0t with no read outstanding", port_name(p), $time);
   end else begin
      e = exp_q.pop_front();
      if (e.port != p) begin
         err_cnt++;
         $display("Fail t=%0t response port expected %s got %s",
                  $time, port_name(e.port), port_name(p));
      end
      if (r.tag != e.tag) begin
         err_cnt++;
         $display("Fail t=%0t o_%s_resp.tag expected %h got %h",
                  $time, port_name(p), e.tag, r.tag);
      end
      if (r.data != e.data) begin
         err_cnt++;
         $display("Fail t=%0t o_%s_resp.data expected %h got %h",
                  $time, port_name(p), e.data, r.data);
      end
      if (e.lat_chk && (cyc - e.acc_cyc) != RD_LAT) begin
         err_cnt++;
         $display("Fail t=%0t o_%s_resp_valid latency expected %0d got %0d",
                  $time, port_name(p), RD_LAT, cyc - e.acc_cyc);
      end
   end
endtask

task automatic watch_responses();
   forever begin
      @(negedge clk);
      if (ic_vld && ic_rdy) check_response(SRC_IC, ic_resp);
      if (l1d_vld && l1d_rdy) check_response(SRC_L1D, l1d_resp);
      if (ptw_vld && ptw_rdy) check_response(SRC_PTW, ptw_resp);
   end
endtask

// keeps ic ready low until request ready has been low for a few cycles
task automatic hold_ic_resp();
   mem_resp_t held;
   logic      have;
   logic      stalled;
   int        hold;
   int        t;
   have = 1'b0;
   stalled = 1'b0;
   hold = 0;
   t = 0;
   while (hold < 6 && !timed_out) begin
      @(negedge clk);
      if (have && !ic_vld) begin
         err_cnt++;
         $display("Fail t=%0t o_ic_resp_valid expected 1 got 0", $time);
      end else if (have && ic_resp != held) begin
         err_cnt++;
         $display("Fail t=%0t o_ic_resp expected %h got %h", $time, held, ic_resp);
      end else if (ic_vld && !have) begin
         held = ic_resp;
         have = 1'b1;
      end
      if (req_valid[SRC_IC] && !req_ready[SRC_IC]) stalled = 1'b1;
      if (stalled) hold++;
      t++;
      if (t > TIMEOUT) begin
         timed_out = 1'b1;
         err_cnt++;
         $display("timeout: ic request ready never dropped under back-pressure");
      end
   end
   @(posedge clk);
   #1;
   ic_rdy = 1'b1;
endtask

// holds a response port for a few cycles once its response is valid
task automatic stall_port(input src_id_t p);
   int hold;
   int t;
   hold = 0;
   t = 0;
   while (hold < 3 && !timed_out) begin
      @(negedge clk);
      if ((p == SRC_L1D) ? l1d_vld : ptw_vld) hold++;
      t++;
      if (t > TIMEOUT) begin
         timed_out = 1'b1;
         err_cnt++;
         $display("timeout: no %s response arrived while its ready was low", port_name(p));
      end
   end
   @(posedge clk);
   #1;
   if (p == SRC_L1D) begin
      l1d_rdy = 1'b1;
   end else begin
      ptw_rdy = 1'b1;
   end
endtask

task automatic drain_responses();
   int t;
   t = 0;
   while (exp_q.size() != 0 && !timed_out) begin
      @(negedge clk);
      t++;
      if (t > TIMEOUT) begin
         timed_out = 1'b1;
         err_cnt++;
         $display("timeout: %0d read responses never arrived", exp_q.size());
      end
   end
   @(posedge clk);
   #1;
endtask

initial begin
   int idx;
   int lo;
   int test;
   int err_start;
   void'($urandom(32'h1403));
   rst_n = 1'b0;
   ic_rdy = 1'b1;
   l1d_rdy = 1'b1;
   ptw_rdy = 1'b1;
   bp_mode = 1'b0;
   timed_out = 1'b0;
   err_cnt = 0;
   pass_cnt = 0;
   fail_cnt = 0;
   for (int p = 0; p < 4; p++) begin
      req_valid[p] = 1'b0;
      req_pl[p] = '0;
   end
   build_table();
   repeat (5) @(posedge clk);
   #1;
   rst_n = 1'b1;
   fork
      watch_responses();
   join_none
   idx = 0;
   while (idx < rows.size() && !timed_out) begin
      test = rows[idx].test;
      err_start = err_cnt;
      if (test == 5) begin
         bp_mode = 1'b1;
         ic_rdy = 1'b0;
         fork
            hold_ic_resp();
         join_none
      end
      if (test == 6) begin
         // l1d and then ptw responses are held back in turn
         bp_mode = 1'b1;
         l1d_rdy = 1'b0;
         ptw_rdy = 1'b0;
         fork
            begin
               stall_port(SRC_L1D);
               stall_port(SRC_PTW);
            end
         join_none
      end
      while (idx < rows.size() && rows[idx].test == test && !timed_out) begin
         lo = idx;
         while (idx < rows.size() && rows[idx].test == test && rows[idx].wave == rows[lo].wave)
            idx++;
         issue_wave(lo, idx);
      end
      drain_responses();
      bp_mode = 1'b0;
      if (err_cnt == err_start) begin
         pass_cnt++;
         $display("test %0d %s: pass", test, test_name(test));
      end else begin
         fail_cnt++;
         $display("test %0d %s: fail with %0d errors", test, test_name(test), err_cnt - err_start);
      end
   end
   $display("tests passed %0d, tests failed %0d, errors %0d, assertion failures %0d",
            pass_cnt, fail_cnt, err_cnt, dut.u_msrh_l2_assert.fail_cnt);
   if (err_cnt == 0 && !timed_out && dut.u_msrh_l2_assert.fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
   end else begin
      $display("SOME TESTS FAILED");
   end
   $finish;
end

endmodule // msrh_l2_tb

`default_nettype wire
